//--- project.f
frameBufPkg.sv
dualPortRam.sv
txnFifo.sv
frameChecker.sv
regCtrl.sv
frameBufTop.sv
tbClockGen.sv
frameBufTb.sv

//--- run.sh
#!/bin/sh
# Compile the frame buffer testbench with Verilator and run it into sim.log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --top-module frameBufTb -f project.f -o frameBufSim \
    && ./obj_dir/frameBufSim > sim.log 2>&1 \
    || { echo "Build or run of the simulation did not complete"; exit 1; }

grep -q "TESTBENCH FAILED" sim.log && { echo "Simulation reported a failure, see sim.log"; exit 1; }
echo "Simulation finished without failures, see sim.log"
exit 0

//--- framePatterns.mem
// One beat per line: bit 8 is the last flag, bits 7 to 0 the data byte
// A frame is good when the XOR of all its bytes is zero, FFF ends the list
012
034
056
170
0A5
05A
1F0
001
002
004
008
10F
0C3
03C
0AA
155
055
154
080
040
020
010
0F0
100
07E
0E7
199
100
133
FFF

//--- frameBufTb.sv
`timescale 1ns/10ps

module frameBufTb
    import frameBufPkg::*;
();

    logic        clk;
    logic        rstN;
    rxBeat_t     rxBeat;
    logic        rxReady;
    axilReq_t    axilReq;
    axilRsp_t    axilRsp;

    // Pattern words hold the last flag in bit 8 and the byte in bits 7 to 0
    logic [11:0] patMem [64];
    int          patWords;
    int          cycleLimit;
    int          cycles;

    // Reference model with the bytes of good frames in stream order, the frame counts
    // and the bytes held
    logic [7:0]  expQ [$];
    int          goodExp;
    int          badExp;
    int          heldBytes;

    int          errors;
    int          stallCycles;
    logic        streamGo;
    logic        streamDone;
    logic [31:0] lcgState;

    // Requests the DUT has taken on the AW and W pair and on AR
    int          writeTakes = 0;
    int          readTakes = 0;

    tbClockGen clkGen0 (
        .clk_o  (clk),
        .rstN_o (rstN)
    );

    frameBufTop dut0 (
        .clk_i     (clk),
        .rstN_i    (rstN),
        .rxBeat_i  (rxBeat),
        .rxReady_o (rxReady),
        .axilReq_i (axilReq),
        .axilRsp_o (axilRsp)
    );

    // Linear congruential generator for the idle gaps between beats
    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState;
    endfunction

    task automatic reportError(input string msg);
        errors++;
        $display("Error at %0t ns: %s", $time, msg);
    endtask

    // Walk the pattern list up to FFF and sort every frame by its XOR
    task automatic buildModel();
        logic [7:0] frameBytes [$];
        logic [7:0] frameXor;
        frameXor = '0;
        patWords = 0;
        while (patWords < 64 && patMem[patWords] !== 12'hFFF) begin
            frameBytes.push_back(patMem[patWords][7:0]);
            frameXor ^= patMem[patWords][7:0];
            if (patMem[patWords][8]) begin
                if (frameXor == 8'h00) begin
                    goodExp++;
                    foreach (frameBytes[k]) begin
                        expQ.push_back(frameBytes[k]);
                    end
                end else begin
                    badExp++;
                end
                frameBytes.delete();
                frameXor = '0;
            end
            patWords++;
        end
    endtask

    // Called on a falling edge and returns on the falling edge after the beat is taken
    task automatic sendBeat(input logic lastBit, input logic [7:0] byteVal);
        rxBeat.valid = 1'b1;
        rxBeat.last = lastBit;
        rxBeat.data = byteVal;
        // Ready only moves on rising edges, so its value here decides the coming edge
        while (!rxReady) begin
            stallCycles++;
            @(negedge clk);
        end
        stallCycles = 0;
        @(negedge clk);
        rxBeat.valid = 1'b0;
        rxBeat.last = 1'b0;
    endtask

    // Ready is sampled on the rising edge where the DUT takes the request
    always @(posedge clk) begin
        if (axilReq.awValid && axilReq.wValid && axilRsp.awReady && axilRsp.wReady) begin
            writeTakes <= writeTakes + 1;
        end
        if (axilReq.arValid && axilRsp.arReady) begin
            readTakes <= readTakes + 1;
        end
    end

    // AXI4-Lite write with address and data presented together
    task automatic writeReg(input logic [AXI_ADDR_WID-1:0] addr,
                            input logic [AXI_DATA_WID-1:0] data, output logic [1:0] resp);
        int takesBefore;
        @(negedge clk);
        takesBefore = writeTakes;
        axilReq.awValid = 1'b1;
        axilReq.awAddr = addr;
        axilReq.wValid = 1'b1;
        axilReq.wData = data;
        axilReq.wStrb = 4'hF;
        @(negedge clk);
        while (writeTakes == takesBefore) begin
            @(negedge clk);
        end
        axilReq.awValid = 1'b0;
        axilReq.wValid = 1'b0;
        while (!axilRsp.bValid) begin
            @(negedge clk);
        end
        resp = axilRsp.bResp;
        axilReq.bReady = 1'b1;
        @(negedge clk);
        axilReq.bReady = 1'b0;
    endtask

    // AXI4-Lite read that samples the registered R payload once rValid shows up
    task automatic readReg(input logic [AXI_ADDR_WID-1:0] addr,
                           output logic [AXI_DATA_WID-1:0] data, output logic [1:0] resp);
        int takesBefore;
        @(negedge clk);
        takesBefore = readTakes;
        axilReq.arValid = 1'b1;
        axilReq.arAddr = addr;
        @(negedge clk);
        while (readTakes == takesBefore) begin
            @(negedge clk);
        end
        axilReq.arValid = 1'b0;
        while (!axilRsp.rValid) begin
            @(negedge clk);
        end
        data = axilRsp.rData;
        resp = axilRsp.rResp;
        axilReq.rReady = 1'b1;
        @(negedge clk);
        axilReq.rReady = 1'b0;
    endtask

    // Stream every pattern word and keep track of the bytes the FIFO holds
    initial begin : streamProc
        int         gap;
        int         frameLen;
        logic [7:0] frameXor;
        frameLen = 0;
        frameXor = '0;
        wait (streamGo);
        @(negedge clk);
        for (int i = 0; i < patWords; i++) begin
            gap = int'(nextRand() >> 16) % 4;
            repeat (gap) @(negedge clk);
            sendBeat(patMem[i][8], patMem[i][7:0]);
            heldBytes++;
            frameLen++;
            frameXor ^= patMem[i][7:0];
            if (patMem[i][8]) begin
                // A bad frame gives back all of its space
                if (frameXor != 8'h00) begin
                    heldBytes -= frameLen;
                end
                frameLen = 0;
                frameXor = '0;
            end
        end
        streamDone = 1'b1;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycleLimit) begin
            $display("Timeout: the test did not finish within %0d clock cycles", cycleLimit);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial begin : mainProc
        logic [31:0] word;
        logic [1:0]  resp;
        int          pending;
        int          readIdx;
        logic        resumeSeen;
        rxBeat = '0;
        axilReq = '0;
        errors = 0;
        cycles = 0;
        goodExp = 0;
        badExp = 0;
        heldBytes = 0;
        stallCycles = 0;
        streamGo = 1'b0;
        streamDone = 1'b0;
        lcgState = 32'd6880;
        $readmemh("framePatterns.mem", patMem);
        buildModel();
        if (patWords == 64) begin
            $display("The pattern file has no end marker, so no test was run");
            $display("TESTBENCH FAILED");
            $finish;
        end else begin
            cycleLimit = 200 * patWords + 2000;
        end
        @(posedge rstN);

        // Empty FIFO, unknown offset and the status word right after reset
        readReg(REG_DATA, word, resp);
        if (resp != RESP_OKAY || word != 32'h0) begin
            reportError($sformatf("empty DATA read gave %h, resp %0d", word, resp));
        end
        readReg(4'hC, word, resp);
        if (resp != RESP_SLVERR) begin
            reportError($sformatf("read of offset C gave resp %0d", resp));
        end
        writeReg(4'hC, 32'h1, resp);
        if (resp != RESP_SLVERR) begin
            reportError($sformatf("write to offset C gave resp %0d", resp));
        end
        readReg(REG_STATUS, word, resp);
        if (resp != RESP_OKAY || word != 32'h0) begin
            reportError($sformatf("STATUS after reset was %h, resp %0d", word, resp));
        end

        // Stream with no reads until ingress stalls on a full FIFO
        streamGo = 1'b1;
        while (stallCycles < 20) begin
            @(negedge clk);
        end
        if (rxReady || heldBytes != FIFO_ENTRIES - 1) begin
            reportError($sformatf("stall with ready %b and %0d bytes held", rxReady, heldBytes));
        end
        readReg(REG_STATUS, word, resp);
        if (word[1:0] != 2'b11) begin
            reportError($sformatf("STATUS during the stall was %h", word));
        end

        // Read three bytes, then rewind to the last committed point
        for (int k = 0; k < 3; k++) begin
            readReg(REG_DATA, word, resp);
            if (word[8] !== 1'b1 || word[7:0] !== expQ[k]) begin
                reportError($sformatf("DATA read %0d gave %h, expected %h", k, word, expQ[k]));
            end
        end
        writeReg(REG_CTRL, 32'h2, resp);

        // The first reads of the drain see the rewound bytes again
        pending = 0;
        readIdx = 0;
        resumeSeen = 1'b0;
        while (readIdx + pending < expQ.size() || !streamDone) begin
            readReg(REG_DATA, word, resp);
            if (word[8]) begin
                if (readIdx + pending >= expQ.size()) begin
                    reportError($sformatf("DATA read gave %h beyond the good frames", word));
                end else if (word[7:0] !== expQ[readIdx + pending]) begin
                    reportError($sformatf("byte %0d was %h, expected %h", readIdx + pending,
                                          word[7:0], expQ[readIdx + pending]));
                end
                pending++;
            end else begin
                if (pending > 0) begin
                    // With both bits set the commit takes priority over the rewind
                    writeReg(REG_CTRL, 32'h3, resp);
                    readIdx += pending;
                    heldBytes -= pending;
                    pending = 0;
                    if (!resumeSeen) begin
                        for (int w = 0; w < 8 && !rxReady; w++) begin
                            @(negedge clk);
                        end
                        if (!rxReady) begin
                            reportError("ingress stayed stalled after the commit");
                        end
                        resumeSeen = 1'b1;
                    end
                end
                repeat (3) @(negedge clk);
            end
        end
        if (pending > 0) begin
            writeReg(REG_CTRL, 32'h1, resp);
        end
        repeat (4) @(negedge clk);

        // Frame counters and an empty FIFO at the end
        readReg(REG_STATUS, word, resp);
        if (word[15:8] != goodExp[7:0] || word[23:16] != badExp[7:0] || word[1:0] != 2'b00) begin
            reportError($sformatf("final STATUS %h, expected %0d good and %0d bad",
                                  word, goodExp, badExp));
        end
        readReg(REG_DATA, word, resp);
        if (word != 32'h0) begin
            reportError($sformatf("DATA read on the drained FIFO gave %h", word));
        end

        $display("Summary: %0d bytes, %0d good and %0d bad frames, %0d errors",
                 expQ.size(), goodExp, badExp, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- tbClockGen.sv
`timescale 1ns/10ps

module tbClockGen (
    output logic clk_o,
    output logic rstN_o
);

    // 10 ns period, rising edges at 5, 15, 25 and so on
    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // Reset spans 16 rising edges and lifts on a falling edge, away from the sampling edge
    initial begin
        rstN_o = 1'b0;
        repeat (16) @(posedge clk_o);
        @(negedge clk_o);
        rstN_o = 1'b1;
    end

endmodule

//--- frameBufTop.sv
`timescale 1ns/10ps

module frameBufTop
    import frameBufPkg::*;
(
    input  logic     clk_i,
    input  logic     rstN_i,

    // Byte stream ingress
    input  rxBeat_t  rxBeat_i,
    output logic     rxReady_o,

    // Software access
    input  axilReq_t axilReq_i,
    output axilRsp_t axilRsp_o
);

    // Checker to FIFO
    logic                wrValid;
    logic [DATA_WID-1:0] wrData;
    fillCtrl_t           fillCtrl;
    frameStats_t         stats;

    // FIFO status and read side
    logic                full;
    logic                dataAvailable;
    logic [DATA_WID-1:0] rdData;
    popCtrl_t            popCtrl;

    // FIFO to storage
    memWr_t              memWr;
    logic [ADDR_WID-1:0] memRAddr;
    logic [DATA_WID-1:0] memRData;

    // Checksum and frame boundary handling
    frameChecker checker0 (
        .clk_i      (clk_i),
        .rstN_i     (rstN_i),
        .rxBeat_i   (rxBeat_i),
        .fifoFull_i (full),
        .rxReady_o  (rxReady_o),
        .wrValid_o  (wrValid),
        .wrData_o   (wrData),
        .fillCtrl_o (fillCtrl),
        .stats_o    (stats)
    );

    // Transactional FIFO control
    txnFifo fifo0 (
        .clk_i           (clk_i),
        .rstN_i          (rstN_i),
        .wrValid_i       (wrValid),
        .wrData_i        (wrData),
        .fillCtrl_i      (fillCtrl),
        .full_o          (full),
        .popCtrl_i       (popCtrl),
        .dataAvailable_o (dataAvailable),
        .rdData_o        (rdData),
        .memWr_o         (memWr),
        .memRAddr_o      (memRAddr),
        .memRData_i      (memRData)
    );

    // FIFO storage
    dualPortRam ram0 (
        .clk_i   (clk_i),
        .memWr_i (memWr),
        .rAddr_i (memRAddr),
        .rData_o (memRData)
    );

    // Register block
    regCtrl regs0 (
        .clk_i           (clk_i),
        .rstN_i          (rstN_i),
        .axilReq_i       (axilReq_i),
        .axilRsp_o       (axilRsp_o),
        .dataAvailable_i (dataAvailable),
        .fifoFull_i      (full),
        .rdData_i        (rdData),
        .stats_i         (stats),
        .popCtrl_o       (popCtrl)
    );

endmodule

//--- regCtrl.sv
`timescale 1ns/10ps

module regCtrl
    import frameBufPkg::*;
(
    input  logic                clk_i,
    input  logic                rstN_i,

    // AXI4-Lite slave port
    input  axilReq_t            axilReq_i,
    output axilRsp_t            axilRsp_o,

    // FIFO read side status and data
    input  logic                dataAvailable_i,
    input  logic                fifoFull_i,
    input  logic [DATA_WID-1:0] rdData_i,

    // Frame counters
    input  frameStats_t         stats_i,

    // Read side control towards the FIFO
    output popCtrl_t            popCtrl_o
);

    logic                    writeTake;
    logic                    readTake;
    logic                    ctrlDone;
    logic                    popHit;

    // Pending responses
    logic                    bValid;
    logic                    rValid;
    logic [1:0]              bResp;
    logic [1:0]              rResp;
    logic [AXI_DATA_WID-1:0] rData;

    // Decoded read word for the address in flight
    logic [AXI_DATA_WID-1:0] readWord;

    // Any of the three register offsets is a valid target
    function automatic logic knownAddr(input logic [AXI_ADDR_WID-1:0] addr);
        return (addr == REG_STATUS) || (addr == REG_DATA) || (addr == REG_CTRL);
    endfunction

    // A write needs both address and data, and a free B slot
    assign writeTake = axilReq_i.awValid && axilReq_i.wValid && !bValid;

    // A CTRL write with either bit set ends the pop transaction in this very cycle
    assign ctrlDone = writeTake && (axilReq_i.awAddr == REG_CTRL)
                      && (axilReq_i.wData[0] || axilReq_i.wData[1]);

    // Reads wait while a transaction end is going out, so pop and done stay apart
    assign readTake = axilReq_i.arValid && !rValid && !ctrlDone;

    // A DATA read pops only when a committed byte is waiting
    assign popHit = readTake && (axilReq_i.arAddr == REG_DATA) && dataAvailable_i;

    // Commit wins over rewind when both bits are set
    assign popCtrl_o.pop = popHit;
    assign popCtrl_o.done = ctrlDone;
    assign popCtrl_o.success = axilReq_i.wData[0];

    // Register map for reads
    always_comb begin
        readWord = '0;
        case (axilReq_i.arAddr)
            REG_STATUS: begin
                readWord[0] = dataAvailable_i;
                readWord[1] = fifoFull_i;
                readWord[15:8] = stats_i.goodCount;
                readWord[23:16] = stats_i.badCount;
            end
            REG_DATA: begin
                // Bit 8 tells software whether the byte field holds a real byte
                readWord[8] = popHit;
                readWord[7:0] = popHit ? rdData_i : '0;
            end
            default: begin
                readWord = '0;
            end
        endcase
    end

    // Handshake state of both channels
    always_ff @(posedge clk_i or negedge rstN_i) begin
        if (!rstN_i) begin
            bValid <= 1'b0;
            rValid <= 1'b0;
        end else begin
            // B holds until the master takes it
            if (writeTake) begin
                bValid <= 1'b1;
            end else if (axilReq_i.bReady) begin
                bValid <= 1'b0;
            end

            // R holds until the master takes it
            if (readTake) begin
                rValid <= 1'b1;
            end else if (axilReq_i.rReady) begin
                rValid <= 1'b0;
            end
        end
    end

    // Response payload, captured in the cycle the request is taken
    always_ff @(posedge clk_i) begin
        if (writeTake) begin
            bResp <= knownAddr(axilReq_i.awAddr) ? RESP_OKAY : RESP_SLVERR;
        end
        if (readTake) begin
            rResp <= knownAddr(axilReq_i.arAddr) ? RESP_OKAY : RESP_SLVERR;
            rData <= readWord;
        end
    end

    // Drive the slave channels
    always_comb begin
        axilRsp_o.awReady = writeTake;
        axilRsp_o.wReady = writeTake;
        axilRsp_o.bValid = bValid;
        axilRsp_o.bResp = bResp;
        axilRsp_o.arReady = readTake;
        axilRsp_o.rValid = rValid;
        axilRsp_o.rData = rData;
        axilRsp_o.rResp = rResp;
    end

endmodule

//--- frameChecker.sv
`timescale 1ns/10ps

module frameChecker
    import frameBufPkg::*;
(
    input  logic                clk_i,
    input  logic                rstN_i,

    // Incoming byte stream
    input  rxBeat_t             rxBeat_i,
    input  logic                fifoFull_i,
    output logic                rxReady_o,

    // Fill side of the FIFO
    output logic                wrValid_o,
    output logic [DATA_WID-1:0] wrData_o,
    output fillCtrl_t           fillCtrl_o,

    // Frame counters for the status register
    output frameStats_t         stats_o
);

    logic                accept;
    logic                endFlag;
    logic [DATA_WID-1:0] xorAcc;
    logic                frameGood;

    // The cycle after a last beat belongs to the transaction end, so no beat is taken then
    assign rxReady_o = !fifoFull_i && !endFlag;
    assign accept = rxBeat_i.valid && rxReady_o;

    // Accepted bytes go straight into the FIFO
    assign wrValid_o = accept;
    assign wrData_o = rxBeat_i.data;

    // The check byte is already folded in, so a good frame leaves zero behind
    assign frameGood = xorAcc == '0;

    assign fillCtrl_o.done = endFlag;
    assign fillCtrl_o.success = frameGood;

    always_ff @(posedge clk_i or negedge rstN_i) begin
        if (!rstN_i) begin
            endFlag <= 1'b0;
            xorAcc <= '0;
            stats_o <= '0;
        end else begin
            // Flag the cycle that closes the frame
            endFlag <= accept && rxBeat_i.last;

            if (endFlag) begin
                // Frame closed, start the next checksum from zero
                xorAcc <= '0;
                if (frameGood) begin
                    stats_o.goodCount <= stats_o.goodCount + 1'b1;
                end else begin
                    stats_o.badCount <= stats_o.badCount + 1'b1;
                end
            end else if (accept) begin
                xorAcc <= xorAcc ^ rxBeat_i.data;
            end
        end
    end

endmodule

//--- txnFifo.sv
`timescale 1ns/10ps

module txnFifo
    import frameBufPkg::*;
(
    input  logic                clk_i,
    input  logic                rstN_i,

    // Fill side, a transaction end never coincides with a write handshake
    input  logic                wrValid_i,
    input  logic [DATA_WID-1:0] wrData_i,
    input  fillCtrl_t           fillCtrl_i,
    output logic                full_o,

    // Pop side, same rule for done against pop
    input  popCtrl_t            popCtrl_i,
    output logic                dataAvailable_o,
    output logic [DATA_WID-1:0] rdData_o,

    // External dual port memory
    output memWr_t              memWr_o,
    output logic [ADDR_WID-1:0] memRAddr_o,
    input  logic [DATA_WID-1:0] memRData_i
);

    // Committed pointers mark what the other side may see or reuse
    logic [ADDR_WID-1:0] dataCounter;
    logic [ADDR_WID-1:0] readCounter;

    // Working pointers move with every handshake inside a transaction
    logic [ADDR_WID-1:0] transDataCounter;
    logic [ADDR_WID-1:0] transReadCounter;

    // Committed read pointer minus one, kept as a register to shorten the full path
    logic [ADDR_WID-1:0] prevReadCounter;

    logic writeHandshake;
    logic readHandshake;

    // Step a pointer forward, wrapping at the last memory entry
    function automatic logic [ADDR_WID-1:0] nextIdx(input logic [ADDR_WID-1:0] idx);
        return (idx == FIFO_LAST_IDX) ? '0 : idx + 1'b1;
    endfunction

    // Step a pointer backward, wrapping below zero to the last entry
    function automatic logic [ADDR_WID-1:0] prevIdx(input logic [ADDR_WID-1:0] idx);
        return (idx == '0) ? FIFO_LAST_IDX : idx - 1'b1;
    endfunction

    // Only committed frames are visible to the reader
    assign dataAvailable_o = transReadCounter != dataCounter;

    // Full when the working write pointer has caught up with the slot before the committed read
    assign full_o = transDataCounter == prevReadCounter;

    assign writeHandshake = wrValid_i && !full_o;
    assign readHandshake = popCtrl_i.pop && dataAvailable_o;

    // Memory hookup
    assign memWr_o.en = writeHandshake;
    assign memWr_o.addr = transDataCounter;
    assign memWr_o.data = wrData_i;
    assign memRAddr_o = transReadCounter;
    assign rdData_o = memRData_i;

    // Fill side pointers
    always_ff @(posedge clk_i or negedge rstN_i) begin
        if (!rstN_i) begin
            dataCounter <= '0;
            transDataCounter <= '0;
        end else if (fillCtrl_i.done) begin
            if (fillCtrl_i.success) begin
                // Good frame, publish everything written so far
                dataCounter <= transDataCounter;
            end else begin
                // Bad frame, drop its bytes by pulling the working pointer back
                transDataCounter <= dataCounter;
            end
        end else if (writeHandshake) begin
            transDataCounter <= nextIdx(transDataCounter);
        end
    end

    // Pop side pointers
    always_ff @(posedge clk_i or negedge rstN_i) begin
        if (!rstN_i) begin
            readCounter <= '0;
            transReadCounter <= '0;
            prevReadCounter <= FIFO_LAST_IDX;
        end else if (popCtrl_i.done) begin
            if (popCtrl_i.success) begin
                // Commit frees the space of every byte read so far
                readCounter <= transReadCounter;
                prevReadCounter <= prevIdx(transReadCounter);
            end else begin
                // Rewind, the same bytes will be read again
                transReadCounter <= readCounter;
            end
        end else if (readHandshake) begin
            transReadCounter <= nextIdx(transReadCounter);
        end
    end

endmodule

//--- dualPortRam.sv
`timescale 1ns/10ps

module dualPortRam
    import frameBufPkg::*;
(
    input  logic                clk_i,

    // Write port, taken on the rising edge
    input  memWr_t              memWr_i,

    // Read port, data follows the address in the same cycle
    input  logic [ADDR_WID-1:0] rAddr_i,
    output logic [DATA_WID-1:0] rData_o
);

    // Storage for the FIFO bytes
    // Only entries behind the FIFO pointers are ever read, so stale contents never leak out
    logic [DATA_WID-1:0] mem [FIFO_ENTRIES];

    // Clocked write
    always_ff @(posedge clk_i) begin
        if (memWr_i.en) begin
            mem[memWr_i.addr] <= memWr_i.data;
        end
    end

    // Combinational read
    // The FIFO keeps its read pointer inside 0 to FIFO_ENTRIES-1 at all times
    assign rData_o = mem[rAddr_i];

endmodule

//--- frameBufPkg.sv
package frameBufPkg;

    // FIFO geometry
    // Twelve entries do not fill the 4 bit pointer space, so pointers wrap by bounds check
    localparam int ADDR_WID = 4;
    localparam int DATA_WID = 8;
    localparam int FIFO_ENTRIES = 12;
    localparam logic [ADDR_WID-1:0] FIFO_LAST_IDX = ADDR_WID'(FIFO_ENTRIES - 1);

    // AXI4-Lite bus geometry
    localparam int AXI_ADDR_WID = 4;
    localparam int AXI_DATA_WID = 32;

    // Register offsets
    localparam logic [AXI_ADDR_WID-1:0] REG_STATUS = 4'h0;
    localparam logic [AXI_ADDR_WID-1:0] REG_DATA = 4'h4;
    localparam logic [AXI_ADDR_WID-1:0] REG_CTRL = 4'h8;

    // AXI response codes
    localparam logic [1:0] RESP_OKAY = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // One beat of the incoming byte stream, last marks the check byte of a frame
    typedef struct packed {
        logic                valid;
        logic                last;
        logic [DATA_WID-1:0] data;
    } rxBeat_t;

    // Write port of the FIFO storage
    typedef struct packed {
        logic                en;
        logic [ADDR_WID-1:0] addr;
        logic [DATA_WID-1:0] data;
    } memWr_t;

    // End of a fill transaction, success commits and a clear success rolls back
    typedef struct packed {
        logic done;
        logic success;
    } fillCtrl_t;

    // Read side control, done never shares a cycle with pop
    typedef struct packed {
        logic pop;
        logic done;
        logic success;
    } popCtrl_t;

    // Frame statistics, both counters wrap
    typedef struct packed {
        logic [7:0] goodCount;
        logic [7:0] badCount;
    } frameStats_t;

    // Master to slave AXI4-Lite channels
    typedef struct packed {
        logic                      awValid;
        logic [AXI_ADDR_WID-1:0]   awAddr;
        logic                      wValid;
        logic [AXI_DATA_WID-1:0]   wData;
        logic [AXI_DATA_WID/8-1:0] wStrb;
        logic                      bReady;
        logic                      arValid;
        logic [AXI_ADDR_WID-1:0]   arAddr;
        logic                      rReady;
    } axilReq_t;

    // Slave to master AXI4-Lite channels
    typedef struct packed {
        logic                    awReady;
        logic                    wReady;
        logic                    bValid;
        logic [1:0]              bResp;
        logic                    arReady;
        logic                    rValid;
        logic [AXI_DATA_WID-1:0] rData;
        logic [1:0]              rResp;
    } axilRsp_t;

endpackage
